/* verilog.f */
+incdir+include
rtl/uart_line_pkg.sv
rtl/uart_host_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_channel.sv
rtl/tx_dispatch.sv
rtl/rx_collect.sv
rtl/uart_bank.sv
sim/uart_bank_tb.sv

/* sim/uart_bank_tb.sv */
`include "uart_cfg.svh"

module uart_bank_tb
	import uart_host_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N = `UART_NUM_CHANNELS;
	localparam int DW = `UART_DATA_WIDTH;
	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int FRAME_BITS = DW + 3;
	localparam int FRAME_CLKS = FRAME_BITS * CPB;
	localparam int SEED = 61283;
	localparam int MON_CH = 0;        // line monitor watches this o_serial bit
	localparam int BANG_CH = 1;
	localparam int OVR_CH = 2;
	localparam int BURST_CH = 3;
	localparam int WAIT_LIMIT = 40 * FRAME_CLKS;

	typedef logic [DW-1:0] byte_t;

	logic         clk;
	logic         reset;
	logic         i_tx_valid;
	tx_req_t      i_tx_req;
	logic         o_tx_ready;
	logic         o_rx_valid;
	rx_word_t     o_rx_word;
	logic         i_rx_ready;
	logic [N-1:0] o_serial;
	logic [N-1:0] i_serial;
	logic [N-1:0] force_sel;          // 1 = channel input comes from the bit-banger
	logic [N-1:0] bang_bit;
	int           stall_mode;         // 0 ready, 1 random stalls, 2 held low

	rx_word_t     exp_q [N][$];       // reference model, one queue per channel
	byte_t        line_q [$];         // bytes still to appear on the monitored line

	assign i_serial = (o_serial & ~force_sel) | (bang_bit & force_sel);

	uart_bank u_uart_bank (
		.clk       (clk),
		.reset     (reset),
		.i_tx_valid(i_tx_valid),
		.i_tx_req  (i_tx_req),
		.o_tx_ready(o_tx_ready),
		.o_rx_valid(o_rx_valid),
		.o_rx_word (o_rx_word),
		.i_rx_ready(i_rx_ready),
		.o_serial  (o_serial),
		.i_serial  (i_serial)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_rx_word(input rx_word_t got, input rx_word_t exp);
		if (got !== exp)
			report_mismatch($sformatf(
				"rx word ch%0d data %02h p%0b f%0b o%0b, expected ch%0d %02h p%0b f%0b o%0b",
				got.chan, got.data, got.parity_err, got.frame_err, got.overrun,
				exp.chan, exp.data, exp.parity_err, exp.frame_err, exp.overrun));
	endtask

	task automatic check_line_byte(input byte_t got, input byte_t exp);
		if (got !== exp)
			report_mismatch($sformatf("line byte %02h, expected %02h", got, exp));
	endtask

	task automatic check_idle(input logic [N-1:0] got, input logic [N-1:0] exp,
			input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// even parity makes the ones count even, odd parity inverts the bit
	function automatic logic expected_parity(input byte_t data);
		logic p;
		p = (`UART_PARITY_ODD != 0);
		for (int i = 0; i < DW; i++)
			p ^= data[i];
		return p;
	endfunction

	task automatic expect_word(input chan_id_t ch, input byte_t d, input logic pe, input logic fe,
			input logic ov);
		rx_word_t w;
		w.chan = ch;
		w.data = d;
		w.parity_err = pe;
		w.frame_err = fe;
		w.overrun = ov;
		exp_q[ch].push_back(w);
	endtask

	// holds the request until the dispatcher takes it
	task automatic send_byte(input chan_id_t ch, input byte_t d);
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		@(negedge clk);
		i_tx_valid = 1'b1;
		i_tx_req.chan = ch;
		i_tx_req.data = d;
		while (!done) begin
			@(posedge clk);
			if (o_tx_ready)
				done = 1'b1;
			else if (++waited > WAIT_LIMIT)
				report_error($sformatf("channel %0d never became ready for a write", ch));
		end
		if (ch == MON_CH)
			line_q.push_back(d);
		@(negedge clk);
		i_tx_valid = 1'b0;
	endtask

	task automatic send_random(input int count);
		chan_id_t ch;
		byte_t d;
		for (int i = 0; i < count; i++) begin
			ch = chan_id_t'($urandom_range(0, N - 1));
			d = byte_t'($urandom);
			expect_word(ch, d, 1'b0, 1'b0, 1'b0);
			send_byte(ch, d);
			repeat ($urandom_range(0, 3)) @(negedge clk);
		end
	endtask

	// ready is combinational on the addressed channel, so address each in turn
	task automatic probe_ready(output logic [N-1:0] rdy);
		for (int k = 0; k < N; k++) begin
			@(negedge clk);
			i_tx_valid = 1'b0;
			i_tx_req.chan = chan_id_t'(k);
			@(posedge clk);
			rdy[k] = o_tx_ready;
		end
	endtask

	task automatic wait_drain();
		int waited;
		logic empty;
		waited = 0;
		empty = 1'b0;
		while (!empty) begin
			@(posedge clk);
			empty = (line_q.size() == 0);
			for (int k = 0; k < N; k++)
				if (exp_q[k].size() != 0)
					empty = 1'b0;
			if (!empty && ++waited > WAIT_LIMIT)
				report_error("expected received words did not arrive in time");
		end
	endtask

	task automatic wait_line_quiet(input int ch);
		int waited;
		int high_cnt;
		waited = 0;
		high_cnt = 0;
		while (high_cnt < 2 * FRAME_CLKS) begin
			@(posedge clk);
			high_cnt = o_serial[ch] ? high_cnt + 1 : 0;
			if (++waited > WAIT_LIMIT)
				report_error($sformatf("serial line %0d never went quiet", ch));
		end
	endtask

	// one cell per bit, with idle cells around the frame
	task automatic drive_frame(input int ch, input byte_t d, input logic flip_parity,
			input logic low_stop);
		logic [FRAME_BITS-1:0] bits;
		bits = {!low_stop, expected_parity(d) ^ flip_parity, d, 1'b0};
		@(negedge clk);
		force_sel[ch] = 1'b1;
		bang_bit[ch] = 1'b1;
		repeat (CPB) @(negedge clk);
		for (int i = 0; i < FRAME_BITS; i++) begin
			bang_bit[ch] = bits[i];
			repeat (CPB) @(negedge clk);
		end
		bang_bit[ch] = 1'b1;
		repeat (2 * CPB) @(negedge clk);
		force_sel[ch] = 1'b0;
	endtask

	task automatic decode_line_frame();
		byte_t got;
		byte_t exp;
		logic par;
		logic stp;
		repeat (CPB / 2 - 1) @(posedge clk);   // middle of the start cell
		if (o_serial[MON_CH] !== 1'b0)
			report_mismatch("start bit went high before mid-cell");
		for (int i = 0; i < DW; i++) begin
			repeat (CPB) @(posedge clk);
			got[i] = o_serial[MON_CH];
		end
		repeat (CPB) @(posedge clk);
		par = o_serial[MON_CH];
		repeat (CPB) @(posedge clk);
		stp = o_serial[MON_CH];
		exp = line_q.pop_front();
		check_line_byte(got, exp);
		if (par !== expected_parity(exp))
			report_mismatch($sformatf("parity bit %b for byte %02h", par, exp));
		if (stp !== 1'b1)
			report_mismatch("stop bit low on the line");
	endtask

	// line monitor on one channel
	initial begin
		int idle;
		idle = 0;
		forever begin
			@(posedge clk);
			if (line_q.size() == 0) begin
				idle = 0;
			end else if (o_serial[MON_CH]) begin
				if (++idle > 2 * FRAME_CLKS)
					report_error("monitored line stayed idle with bytes pending");
			end else begin
				idle = 0;
				decode_line_frame();
			end
		end
	end

	// host receive side, checks every transfer against the model
	initial begin
		chan_id_t ch;
		rx_word_t exp;
		forever begin
			@(posedge clk);
			if (!reset && o_rx_valid && i_rx_ready) begin
				ch = o_rx_word.chan;
				if (exp_q[ch].size() == 0)
					report_error($sformatf("unexpected word %02h on channel %0d",
						o_rx_word.data, ch));
				exp = exp_q[ch].pop_front();
				check_rx_word(o_rx_word, exp);
			end
		end
	end

	// i_rx_ready driver, stalls stay under two frame lengths
	initial begin
		int stall_left;
		int ready_left;
		stall_left = 0;
		ready_left = 0;
		forever begin
			@(negedge clk);
			if (stall_mode == 1) begin
				if (stall_left > 0) begin
					i_rx_ready = 1'b0;
					if (--stall_left == 0)
						ready_left = FRAME_CLKS / 2;   // let the buffers drain
				end else begin
					i_rx_ready = 1'b1;
					if (ready_left > 0)
						ready_left--;
					else if ($urandom_range(0, 15) == 0)
						stall_left = $urandom_range(1, 2 * FRAME_CLKS - 1);
				end
			end else begin
				stall_left = 0;
				ready_left = 0;
				i_rx_ready = (stall_mode == 0);
			end
		end
	end

	initial begin
		for (int i = 0; i < 200000; i++)
			@(posedge clk);
		$display("ERROR: simulation ran past its cycle limit");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [N-1:0] rdy;
		byte_t base;
		void'($urandom(SEED));
		reset = 1'b1;
		i_tx_valid = 1'b0;
		i_tx_req = '0;
		i_rx_ready = 1'b1;
		stall_mode = 0;
		force_sel = '0;
		bang_bit = '1;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		@(posedge clk);
		check_idle(o_serial, '1, "o_serial after reset");
		if (o_rx_valid !== 1'b0)
			report_mismatch("o_rx_valid high after reset");
		probe_ready(rdy);
		check_idle(rdy, '1, "tx ready after reset");

		send_random(24);                 // loopback on all channels
		for (int i = 0; i < 6; i++) begin
			base = byte_t'($urandom);
			expect_word(chan_id_t'(MON_CH), base, 1'b0, 1'b0, 1'b0);
			send_byte(chan_id_t'(MON_CH), base);
		end
		wait_drain();

		base = byte_t'($urandom);
		expect_word(chan_id_t'(BANG_CH), base, 1'b1, 1'b0, 1'b0);
		drive_frame(BANG_CH, base, 1'b1, 1'b0);
		expect_word(chan_id_t'(BANG_CH), ~base, 1'b0, 1'b1, 1'b0);
		drive_frame(BANG_CH, ~base, 1'b0, 1'b1);
		wait_drain();

		stall_mode = 1;
		send_random(32);
		wait_drain();
		stall_mode = 0;
		base = byte_t'($urandom);
		for (int i = 0; i < 6; i++) begin
			expect_word(chan_id_t'(BURST_CH), base + byte_t'(i), 1'b0, 1'b0, 1'b0);
			send_byte(chan_id_t'(BURST_CH), base + byte_t'(i));
			if (i == 4) begin
				probe_ready(rdy);        // one in flight plus four pending
				check_idle(rdy, ~(N'(1) << BURST_CH), "tx ready during burst");
			end
		end
		wait_drain();

		// 3 storage places, frames 4 and 5 get dropped
		stall_mode = 2;
		@(negedge clk);
		base = byte_t'($urandom);
		for (int i = 0; i < 5; i++) begin
			if (i < 3)
				expect_word(chan_id_t'(OVR_CH), base + byte_t'(i), 1'b0, 1'b0, 1'b0);
			send_byte(chan_id_t'(OVR_CH), base + byte_t'(i));
		end
		wait_line_quiet(OVR_CH);
		if (o_rx_valid !== 1'b1)
			report_mismatch("o_rx_valid low while words are held");
		stall_mode = 0;
		expect_word(chan_id_t'(OVR_CH), base + byte_t'(5), 1'b0, 1'b0, 1'b1);
		send_byte(chan_id_t'(OVR_CH), base + byte_t'(5));
		wait_drain();

		repeat (FRAME_CLKS) @(posedge clk);   // dropped frames must stay gone
		check_idle(o_serial, '1, "o_serial at end");
		if (o_rx_valid !== 1'b0)
			report_mismatch("o_rx_valid high with nothing sent");
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* rtl/uart_bank.sv */
`include "uart_cfg.svh"

module uart_bank
	import uart_host_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_tx_valid,
	input  tx_req_t                       i_tx_req,
	output logic                          o_tx_ready,
	output logic                          o_rx_valid,
	output rx_word_t                      o_rx_word,
	input  logic                          i_rx_ready,
	output logic [`UART_NUM_CHANNELS-1:0] o_serial,
	input  logic [`UART_NUM_CHANNELS-1:0] i_serial
);

	logic [`UART_NUM_CHANNELS-1:0] tx_push;
	logic [`UART_NUM_CHANNELS-1:0] tx_credit;
	logic [`UART_DATA_WIDTH-1:0]   tx_data [`UART_NUM_CHANNELS];
	logic [`UART_NUM_CHANNELS-1:0] rx_push;
	logic [`UART_NUM_CHANNELS-1:0] rx_credit;
	rx_word_t                      rx_word [`UART_NUM_CHANNELS];

	tx_dispatch u_tx_dispatch (
		.clk        (clk),
		.reset      (reset),
		.i_tx_valid (i_tx_valid),
		.i_tx_req   (i_tx_req),
		.o_tx_ready (o_tx_ready),
		.o_tx_push  (tx_push),
		.o_tx_data  (tx_data),
		.i_tx_credit(tx_credit)
	);

	for (genvar k = 0; k < `UART_NUM_CHANNELS; k++) begin : g_chan
		uart_channel #(
			.CHAN_ID(k)
		) u_uart_channel (
			.clk        (clk),
			.reset      (reset),
			.i_tx_push  (tx_push[k]),
			.i_tx_data  (tx_data[k]),
			.o_tx_credit(tx_credit[k]),
			.o_serial   (o_serial[k]),
			.i_serial   (i_serial[k]),
			.o_rx_push  (rx_push[k]),
			.o_rx_word  (rx_word[k]),
			.i_rx_credit(rx_credit[k])
		);
	end

	rx_collect u_rx_collect (
		.clk        (clk),
		.reset      (reset),
		.i_rx_push  (rx_push),
		.i_rx_word  (rx_word),
		.o_rx_credit(rx_credit),
		.o_rx_valid (o_rx_valid),
		.o_rx_word  (o_rx_word),
		.i_rx_ready (i_rx_ready)
	);

endmodule

/* rtl/rx_collect.sv */
`include "uart_cfg.svh"

module rx_collect
	import uart_host_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`UART_NUM_CHANNELS-1:0] i_rx_push,
	input  rx_word_t                      i_rx_word [`UART_NUM_CHANNELS],
	output logic [`UART_NUM_CHANNELS-1:0] o_rx_credit,
	output logic                          o_rx_valid,
	output rx_word_t                      o_rx_word,
	input  logic                          i_rx_ready
);

	localparam int N = `UART_NUM_CHANNELS;
	localparam int DEPTH = `UART_RX_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	rx_word_t         buf_mem [N][DEPTH];
	logic [PTR_W-1:0] wr_ptr [N];
	logic [PTR_W-1:0] rd_ptr [N];
	logic [CNT_W-1:0] count [N];
	chan_id_t         rr_last;      // channel served most recently
	chan_id_t         rr_pick;
	chan_id_t         lock_chan;
	chan_id_t         sel;
	logic             rr_found;
	logic             locked;       // host stalled, keep the same word up
	logic             xfer;

	// first non-empty channel after the last one served
	always_comb begin
		rr_pick = rr_last;
		rr_found = 1'b0;
		for (int i = 1; i <= N; i++) begin
			if (!rr_found && count[(int'(rr_last) + i) % N] != '0) begin
				rr_found = 1'b1;
				rr_pick = chan_id_t'((int'(rr_last) + i) % N);
			end
		end
	end

	assign sel = locked ? lock_chan : rr_pick;
	assign o_rx_valid = locked || rr_found;
	assign o_rx_word = buf_mem[sel][rd_ptr[sel]];
	assign xfer = o_rx_valid && i_rx_ready;

	always_comb begin
		for (int k = 0; k < N; k++)
			o_rx_credit[k] = xfer && (sel == chan_id_t'(k));   // word gone, place free
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < N; k++) begin
			if (i_rx_push[k])
				buf_mem[k][wr_ptr[k]] <= i_rx_word[k];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < N; k++) begin
				wr_ptr[k] <= '0;
				rd_ptr[k] <= '0;
				count[k] <= '0;
			end
			rr_last <= chan_id_t'(N - 1);   // channel 0 goes first
			locked <= 1'b0;
			lock_chan <= '0;
		end else begin
			for (int k = 0; k < N; k++) begin
				if (i_rx_push[k])
					wr_ptr[k] <= (wr_ptr[k] == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr[k] + 1'b1;
				if (o_rx_credit[k])
					rd_ptr[k] <= (rd_ptr[k] == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr[k] + 1'b1;
				case ({i_rx_push[k], o_rx_credit[k]})
					2'b10: count[k] <= count[k] + 1'b1;
					2'b01: count[k] <= count[k] - 1'b1;
					default: ;
				endcase
			end
			if (xfer)
				rr_last <= sel;
			locked <= o_rx_valid && !i_rx_ready;
			lock_chan <= sel;
		end
	end

	// channel credit counters keep every buffer from overflowing
	for (genvar k = 0; k < N; k++) begin : g_buf_chk
		a_no_push_when_full: assert property (
			@(posedge clk) disable iff (reset) i_rx_push[k] |-> (count[k] < DEPTH)
		);
	end

	a_word_held: assert property (
		@(posedge clk) disable iff (reset)
		(o_rx_valid && !i_rx_ready) |=> (o_rx_valid && $stable(o_rx_word))
	);

endmodule

/* rtl/tx_dispatch.sv */
`include "uart_cfg.svh"

module tx_dispatch
	import uart_host_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_tx_valid,
	input  tx_req_t                       i_tx_req,
	output logic                          o_tx_ready,
	output logic [`UART_NUM_CHANNELS-1:0] o_tx_push,
	output logic [`UART_DATA_WIDTH-1:0]   o_tx_data [`UART_NUM_CHANNELS],
	input  logic [`UART_NUM_CHANNELS-1:0] i_tx_credit
);

	localparam int CRED_W = $clog2(`UART_TX_FIFO_DEPTH + 1);

	logic [CRED_W-1:0] credit [`UART_NUM_CHANNELS];   // free FIFO entries per channel
	logic              accept;

	// ready follows the addressed channel only
	assign o_tx_ready = (credit[i_tx_req.chan] != '0);
	assign accept = i_tx_valid && o_tx_ready;

	always_comb begin
		for (int k = 0; k < `UART_NUM_CHANNELS; k++) begin
			o_tx_push[k] = accept && (i_tx_req.chan == chan_id_t'(k));
			o_tx_data[k] = i_tx_req.data;    // only the pushed channel latches it
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < `UART_NUM_CHANNELS; k++)
				credit[k] <= CRED_W'(`UART_TX_FIFO_DEPTH);
		end else begin
			for (int k = 0; k < `UART_NUM_CHANNELS; k++) begin
				case ({o_tx_push[k], i_tx_credit[k]})
					2'b10: credit[k] <= credit[k] - 1'b1;
					2'b01: credit[k] <= credit[k] + 1'b1;
					default: ;
				endcase
			end
		end
	end

	// a channel never returns more credits than it was given
	for (genvar k = 0; k < `UART_NUM_CHANNELS; k++) begin : g_credit_chk
		a_credit_max: assert property (
			@(posedge clk) disable iff (reset) credit[k] <= `UART_TX_FIFO_DEPTH
		);
	end

endmodule

/* rtl/uart_channel.sv */
`include "uart_cfg.svh"

module uart_channel
	import uart_host_pkg::*;
#(
	parameter int CHAN_ID = 0
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_tx_push,
	input  logic [`UART_DATA_WIDTH-1:0] i_tx_data,
	output logic                        o_tx_credit,
	output logic                        o_serial,
	input  logic                        i_serial,
	output logic                        o_rx_push,
	output rx_word_t                    o_rx_word,
	input  logic                        i_rx_credit
);

	localparam int TX_DEPTH = `UART_TX_FIFO_DEPTH;
	localparam int TX_PTR_W = $clog2(TX_DEPTH);
	localparam int TX_CNT_W = $clog2(TX_DEPTH + 1);
	localparam int RX_CRED_W = $clog2(`UART_RX_BUF_DEPTH + 1);

	logic [`UART_DATA_WIDTH-1:0] fifo_mem [TX_DEPTH];
	logic [TX_PTR_W-1:0]         wr_ptr;
	logic [TX_PTR_W-1:0]         rd_ptr;
	logic [TX_CNT_W-1:0]         fifo_count;
	logic                        tx_busy;
	logic                        tx_start;

	logic                        rx_valid;
	logic [`UART_DATA_WIDTH-1:0] rx_data;
	logic                        rx_parity_err;
	logic                        rx_frame_err;
	logic [RX_CRED_W-1:0]        rx_credit;     // free places in the collector
	logic                        hold_full;
	logic                        hold_load;
	logic                        overrun_pending;
	rx_word_t                    hold_word;

	// a pop frees a FIFO entry, so it doubles as the credit return
	assign tx_start = (fifo_count != '0) && !tx_busy;
	assign o_tx_credit = tx_start;

	always_ff @(posedge clk) begin
		if (i_tx_push)
			fifo_mem[wr_ptr] <= i_tx_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end else begin
			if (i_tx_push)
				wr_ptr <= (wr_ptr == TX_PTR_W'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (tx_start)
				rd_ptr <= (rd_ptr == TX_PTR_W'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({i_tx_push, tx_start})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: ;
			endcase
		end
	end

	uart_tx u_uart_tx (
		.clk     (clk),
		.reset   (reset),
		.i_start (tx_start),
		.i_data  (fifo_mem[rd_ptr]),
		.o_serial(o_serial),
		.o_busy  (tx_busy)
	);

	uart_rx u_uart_rx (
		.clk         (clk),
		.reset       (reset),
		.i_serial    (i_serial),
		.o_valid     (rx_valid),
		.o_data      (rx_data),
		.o_parity_err(rx_parity_err),
		.o_frame_err (rx_frame_err)
	);

	assign o_rx_push = hold_full && (rx_credit != '0);
	assign o_rx_word = hold_word;
	assign hold_load = rx_valid && (!hold_full || o_rx_push);   // register frees this cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_credit <= RX_CRED_W'(`UART_RX_BUF_DEPTH);
			hold_full <= 1'b0;
			overrun_pending <= 1'b0;
		end else begin
			case ({o_rx_push, i_rx_credit})
				2'b10: rx_credit <= rx_credit - 1'b1;
				2'b01: rx_credit <= rx_credit + 1'b1;
				default: ;
			endcase
			if (hold_load)
				hold_full <= 1'b1;
			else if (o_rx_push)
				hold_full <= 1'b0;
			if (rx_valid && !hold_load)
				overrun_pending <= 1'b1;    // frame dropped
			else if (hold_load)
				overrun_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_load)
			hold_word <= '{
				chan:       chan_id_t'(CHAN_ID),
				data:       rx_data,
				parity_err: rx_parity_err,
				frame_err:  rx_frame_err,
				overrun:    overrun_pending
			};
	end

	// dispatcher credits must keep pushes off a full FIFO
	a_tx_fifo_no_overflow: assert property (
		@(posedge clk) disable iff (reset) i_tx_push |-> (fifo_count < TX_DEPTH)
	);

	// collector may only return what was sent
	a_rx_credit_range: assert property (
		@(posedge clk) disable iff (reset) rx_credit <= `UART_RX_BUF_DEPTH
	);

endmodule

/* rtl/uart_rx.sv */
`include "uart_cfg.svh"

module uart_rx
	import uart_line_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_serial,
	output logic                        o_valid,
	output logic [`UART_DATA_WIDTH-1:0] o_data,
	output logic                        o_parity_err,
	output logic                        o_frame_err
);

	logic [`UART_SYNC_STAGES-1:0] sync;
	logic                         rx_bit;
	rx_state_e                    state;
	logic [CELL_W-1:0]            cell_cnt;
	logic [BIT_W-1:0]             bit_cnt;
	logic [`UART_DATA_WIDTH-1:0]  shreg;
	logic                         sample;      // middle of a data, parity or stop cell

	assign rx_bit = sync[`UART_SYNC_STAGES-1];
	assign sample = (cell_cnt == CELL_W'(`UART_CLKS_PER_BIT - 1));
	assign o_data = shreg;

	always_ff @(posedge clk) begin
		if (reset)
			sync <= '1;
		else
			sync <= {sync[`UART_SYNC_STAGES-2:0], i_serial};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			cell_cnt <= '0;
			bit_cnt <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			cell_cnt <= sample ? '0 : cell_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cell_cnt <= '0;
					bit_cnt <= '0;
					if (!rx_bit)
						state <= RX_START;
				end
				RX_START: begin
					// half a cell in, the line must still be low
					if (cell_cnt == CELL_W'(`UART_CLKS_PER_BIT / 2 - 1)) begin
						cell_cnt <= '0;
						state <= rx_bit ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(`UART_DATA_WIDTH - 1))
							state <= RX_PARITY;
					end
				end
				RX_PARITY: begin
					if (sample)
						state <= RX_STOP;
				end
				default: begin
					// back to idle even on a bad stop bit
					if (sample) begin
						o_valid <= 1'b1;
						state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// character and status registers
	always_ff @(posedge clk) begin
		if (sample) begin
			case (state)
				RX_DATA: shreg <= {rx_bit, shreg[`UART_DATA_WIDTH-1:1]};   // LSB arrives first
				RX_PARITY: o_parity_err <= (rx_bit != frame_parity(shreg));
				RX_STOP: o_frame_err <= !rx_bit;
				default: ;
			endcase
		end
	end

endmodule

/* rtl/uart_tx.sv */
`include "uart_cfg.svh"

module uart_tx
	import uart_line_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,
	input  logic [`UART_DATA_WIDTH-1:0] i_data,
	output logic                        o_serial,
	output logic                        o_busy
);

	tx_state_e             state;
	logic [FRAME_BITS-1:0] shreg;      // bit 0 is on the line
	logic [CELL_W-1:0]     cell_cnt;
	logic [BIT_W-1:0]      bit_cnt;
	logic                  cell_end;

	assign cell_end = (cell_cnt == CELL_W'(`UART_CLKS_PER_BIT - 1));
	assign o_serial = shreg[0];
	assign o_busy = (state != TX_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= TX_IDLE;
			shreg <= '1;               // line idles high
			cell_cnt <= '0;
			bit_cnt <= '0;
		end else if (state == TX_IDLE) begin
			if (i_start) begin
				// start bit goes out on the next cycle
				shreg <= {1'b1, frame_parity(i_data), i_data, 1'b0};
				state <= TX_START;
				cell_cnt <= '0;
				bit_cnt <= '0;
			end
		end else begin
			cell_cnt <= cell_end ? '0 : cell_cnt + 1'b1;
			if (cell_end) begin
				shreg <= {1'b1, shreg[FRAME_BITS-1:1]};   // refill with idle level
				case (state)
					TX_START: state <= TX_DATA;
					TX_DATA: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(`UART_DATA_WIDTH - 1))
							state <= TX_PARITY;
					end
					TX_PARITY: state <= TX_STOP;
					default: state <= TX_IDLE;         // stop cell done
				endcase
			end
		end
	end

	// the channel must wait for the frame to finish before starting another
	a_no_start_while_busy: assert property (
		@(posedge clk) disable iff (reset) i_start |-> !o_busy
	);

	// the frame ends exactly 11 cells after the start bit appears
	a_frame_length: assert property (
		@(posedge clk) disable iff (reset)
		(i_start && !o_busy) |=> o_busy [*FRAME_BITS * `UART_CLKS_PER_BIT] ##1 !o_busy
	);

endmodule

/* rtl/uart_host_pkg.sv */
`include "uart_cfg.svh"

package uart_host_pkg;

	typedef logic [$clog2(`UART_NUM_CHANNELS)-1:0] chan_id_t;

	// host write: which channel, which byte
	typedef struct packed {
		chan_id_t                    chan;
		logic [`UART_DATA_WIDTH-1:0] data;
	} tx_req_t;

	// received character with its status
	typedef struct packed {
		chan_id_t                    chan;
		logic [`UART_DATA_WIDTH-1:0] data;
		logic                        parity_err;  // parity bit mismatch
		logic                        frame_err;   // stop bit sampled low
		logic                        overrun;     // frames were dropped before this one
	} rx_word_t;

endpackage

/* rtl/uart_line_pkg.sv */
`include "uart_cfg.svh"

package uart_line_pkg;

	// start + data + parity + stop
	localparam int FRAME_BITS = `UART_DATA_WIDTH + 3;

	localparam int CELL_W = $clog2(`UART_CLKS_PER_BIT);  // clock-in-cell counter
	localparam int BIT_W = $clog2(`UART_DATA_WIDTH);     // data bit index

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,   // waiting for mid-cell of the start bit
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	// even parity makes the total count of ones even, odd flips the bit
	function automatic logic frame_parity(input logic [`UART_DATA_WIDTH-1:0] data);
		return (^data) ^ (`UART_PARITY_ODD != 0);
	endfunction

endpackage

/* include/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// channel count, kept a power of two so chan_id_t covers it exactly
`define UART_NUM_CHANNELS 4

`define UART_DATA_WIDTH 8        // bits per character, LSB first on the line

`define UART_CLKS_PER_BIT 8      // clocks per bit cell

`define UART_PARITY_ODD 0        // 0 = even, 1 = odd

`define UART_SYNC_STAGES 3       // rx synchronizer flops

// per-channel tx FIFO, also the dispatcher's starting credit count
`define UART_TX_FIFO_DEPTH 4

// per-channel collector buffer, also the channel's starting rx credit count
`define UART_RX_BUF_DEPTH 2

`endif
